// ==== build.f ====
logic/rv32i_isa_pkg.sv
logic/rv32i_pipe_pkg.sv
logic/pipe_reg.sv
logic/mem_stage.sv
logic/load_align.sv
logic/mem_wb_path.sv
sim/tb_mem_wb_path.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_mem_wb_path
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_mem_wb_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_wb_path;

    localparam int clk_period = 40;
    localparam int n_random   = 200;
    // store sweep, load prep plus loads, alu pairs, back-to-back, random mix
    localparam int n_issues   = 12 + 24 + 16 + 6 + n_random;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic        rd_en;
        logic        wr_en;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        flush;
    logic        in_valid;
    logic [6:0]  in_opcode;
    logic [2:0]  in_funct3;
    logic [4:0]  in_rd;
    logic [31:0] in_alu_out;
    logic [31:0] in_store_data;
    logic [31:0] dmem_rdata;
    logic [31:0] dmem_address;
    logic [31:0] dmem_wdata;
    logic        dmem_read;
    logic        dmem_write;
    logic [3:0]  dmem_byte_enable;
    logic        wb_valid;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    // dut memory and the reference copy kept in program order
    logic [31:0] mem [256];
    logic [31:0] shadow [256];
    expect_t     pending [$];
    // expected contents of ex/mem and mem/wb
    expect_t     mem_exp;
    expect_t     wb_exp;
    logic        mem_v = 1'b0;
    logic        wb_v = 1'b0;
    int          seed;
    logic        rand_mode;
    logic [6:0]  alu_ops [8];
    logic [6:0]  rand_ops [6];
    logic [2:0]  load_f3s [5];
    logic [2:0]  store_f3s [3];

    mem_wb_path u_mem_wb_path (
        .clk              (clk),
        .rst              (rst),
        .stall            (stall),
        .flush            (flush),
        .in_valid         (in_valid),
        .in_opcode        (in_opcode),
        .in_funct3        (in_funct3),
        .in_rd            (in_rd),
        .in_alu_out       (in_alu_out),
        .in_store_data    (in_store_data),
        .dmem_rdata       (dmem_rdata),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable),
        .wb_valid         (wb_valid),
        .wb_we            (wb_we),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // magic memory with same-cycle read and byte-enabled write on the edge
    assign dmem_rdata = mem[dmem_address[9:2]];
    always @(posedge clk) begin
        if (dmem_write) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_byte_enable[i]) mem[dmem_address[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx * 8'd37, idx ^ 8'ha5};
    endfunction

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // expected request and write-back for one instruction
    function automatic expect_t predict(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [31:0] alu,
                                        input logic [31:0] sd);
        expect_t     e;
        logic [1:0]  off;
        logic [31:0] word;
        logic [31:0] part;
        off  = alu[1:0];
        word = shadow[alu[9:2]];
        part = word >> (8 * off);
        e = '0;
        e.addr = {alu[31:2], 2'b00};
        e.rd   = rd;
        e.data = alu;
        if (op == rv32i_isa_pkg::op_store) begin
            case (f3)
                rv32i_isa_pkg::sb: e.be = 4'b0001 << off;
                rv32i_isa_pkg::sh: e.be = off[0] ? 4'b0000 : 4'b0011 << off;
                rv32i_isa_pkg::sw: e.be = (off == 2'd0) ? 4'b1111 : 4'b0000;
                default:           e.be = 4'b0000;
            endcase
            e.wr_en = (e.be != 4'b0000);
            // every enabled lane holds its part of a replicated byte, half or word
            case (f3)
                rv32i_isa_pkg::sb: e.wdata = {4{sd[7:0]}};
                rv32i_isa_pkg::sh: e.wdata = {2{sd[15:0]}};
                default:           e.wdata = sd;
            endcase
        end
        if (op == rv32i_isa_pkg::op_load) begin
            e.rd_en = 1'b1;
            // misaligned halves and words give the raw word back
            case (f3)
                rv32i_isa_pkg::lb:  e.data = {{24{part[7]}}, part[7:0]};
                rv32i_isa_pkg::lbu: e.data = {24'd0, part[7:0]};
                rv32i_isa_pkg::lh:  e.data = off[0] ? word : {{16{part[15]}}, part[15:0]};
                rv32i_isa_pkg::lhu: e.data = off[0] ? word : {16'd0, part[15:0]};
                default:            e.data = word;
            endcase
        end
        e.we = (rd != 5'd0) && (op inside {rv32i_isa_pkg::op_load, rv32i_isa_pkg::op_imm,
            rv32i_isa_pkg::op_reg, rv32i_isa_pkg::op_lui, rv32i_isa_pkg::op_auipc,
            rv32i_isa_pkg::op_jal, rv32i_isa_pkg::op_jalr});
        return e;
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, what, got, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // present one instruction until a non-stalled edge takes it
    task automatic issue(input logic [6:0] op, input logic [2:0] f3, input logic [4:0] rd,
                         input logic [31:0] alu, input logic [31:0] sd);
        expect_t e;
        logic    taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            #2;
            in_valid      = 1'b1;
            in_opcode     = op;
            in_funct3     = f3;
            in_rd         = rd;
            in_alu_out    = alu;
            in_store_data = sd;
            stall = rand_mode && (($random(seed) & 7) == 0);
            // flush together with stall leaves the slot held
            flush = rand_mode && (($random(seed) & 15) == 0);
            if (!stall) begin
                taken = 1'b1;
                if (!flush) begin
                    e = predict(op, f3, rd, alu, sd);
                    for (int i = 0; i < 4; i++) begin
                        if (e.be[i]) shadow[alu[9:2]][8*i +: 8] = e.wdata[8*i +: 8];
                    end
                    pending.push_back(e);
                end
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
    endtask

    task automatic random_instr();
        logic [6:0] op;
        logic [2:0] f3;
        op = rand_ops[pick(6)];
        if (op == rv32i_isa_pkg::op_load) f3 = load_f3s[pick(5)];
        else if (op == rv32i_isa_pkg::op_store) f3 = store_f3s[pick(3)];
        else f3 = 3'(pick(8));
        // small window so loads hit earlier stores
        issue(op, f3, 5'(pick(32)), {22'($random(seed)), 10'h200 + 10'(pick(64))},
              $random(seed));
    endtask

    // pipeline occupancy model where a stall freezes both slots
    always @(posedge clk) begin
        if (rst) begin
            mem_v = 1'b0;
            wb_v  = 1'b0;
        end else if (!stall) begin
            wb_v   = mem_v;
            wb_exp = mem_exp;
            mem_v  = in_valid && !flush;
            if (mem_v) mem_exp = pending.pop_front();
        end
    end

    // compare at the falling edge once inputs and outputs have settled
    always @(negedge clk) begin
        if (!rst) begin
            check_equal(32'(dmem_read), 32'(mem_v & mem_exp.rd_en), "dmem_read");
            check_equal(32'(dmem_write), 32'(mem_v & mem_exp.wr_en), "dmem_write");
            check_equal(32'(dmem_byte_enable), mem_v ? 32'(mem_exp.be) : 32'd0, "byte enable");
            if (mem_v) begin
                check_equal(dmem_address, mem_exp.addr, "dmem_address");
                check_equal(dmem_wdata & {{8{mem_exp.be[3]}}, {8{mem_exp.be[2]}},
                            {8{mem_exp.be[1]}}, {8{mem_exp.be[0]}}},
                            mem_exp.wdata & {{8{mem_exp.be[3]}}, {8{mem_exp.be[2]}},
                            {8{mem_exp.be[1]}}, {8{mem_exp.be[0]}}}, "dmem_wdata lanes");
            end
            check_equal(32'(wb_valid), 32'(wb_v), "wb_valid");
            check_equal(32'(wb_we), 32'(wb_v & wb_exp.we), "wb_we");
            if (wb_v) begin
                check_equal(32'(wb_rd), 32'(wb_exp.rd), "wb_rd");
                check_equal(wb_data, wb_exp.data, "wb_data");
            end
        end
    end

    initial begin
        #(clk_period * (n_issues * 3 + 100));
        $display("timeout: pipeline did not drain within %0d cycles", n_issues * 3 + 100);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'h8f56_52b9;
        rand_mode = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_opcode = 7'd0;
        in_funct3 = 3'd0;
        in_rd = 5'd0;
        in_alu_out = 32'd0;
        in_store_data = 32'd0;
        alu_ops = '{rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg, rv32i_isa_pkg::op_lui,
                    rv32i_isa_pkg::op_auipc, rv32i_isa_pkg::op_jal, rv32i_isa_pkg::op_jalr,
                    rv32i_isa_pkg::op_store, rv32i_isa_pkg::op_br};
        rand_ops = '{rv32i_isa_pkg::op_load, rv32i_isa_pkg::op_store, rv32i_isa_pkg::op_imm,
                     rv32i_isa_pkg::op_reg, rv32i_isa_pkg::op_br, rv32i_isa_pkg::op_jalr};
        load_f3s = '{rv32i_isa_pkg::lb, rv32i_isa_pkg::lh, rv32i_isa_pkg::lw,
                     rv32i_isa_pkg::lbu, rv32i_isa_pkg::lhu};
        store_f3s = '{rv32i_isa_pkg::sb, rv32i_isa_pkg::sh, rv32i_isa_pkg::sw};
        for (int i = 0; i < 256; i++) begin
            mem[i]    <= fill_word(8'(i));
            shadow[i] = fill_word(8'(i));
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        // quiet outputs after reset are checked by the compare process
        repeat (3) @(posedge clk);
        // every store width at every offset including misaligned ones
        foreach (store_f3s[k]) begin
            for (int off = 0; off < 4; off++) begin
                issue(rv32i_isa_pkg::op_store, store_f3s[k], 5'd0,
                      32'h40 + 32'(4 * k) + 32'(off), $random(seed));
            end
        end
        for (int w = 0; w < 4; w++) begin
            issue(rv32i_isa_pkg::op_store, rv32i_isa_pkg::sw, 5'd0, 32'h100 + 32'(4 * w),
                  $random(seed));
        end
        foreach (load_f3s[k]) begin
            for (int off = 0; off < 4; off++) begin
                issue(rv32i_isa_pkg::op_load, load_f3s[k], 5'(1 + pick(31)),
                      32'h100 + 32'(4 * (k % 4)) + 32'(off), 32'd0);
            end
        end
        // result opcodes plus store and branch, each with rd 0 and then nonzero
        foreach (alu_ops[k]) begin
            issue(alu_ops[k], 3'(pick(8)), 5'd0, $random(seed), $random(seed));
            issue(alu_ops[k], 3'(pick(8)), 5'(1 + pick(31)), $random(seed), $random(seed));
        end
        // back-to-back store then load of the same bytes
        issue(rv32i_isa_pkg::op_store, rv32i_isa_pkg::sw, 5'd0, 32'h300, 32'hc3a5_961e);
        issue(rv32i_isa_pkg::op_load, rv32i_isa_pkg::lw, 5'd7, 32'h300, 32'd0);
        issue(rv32i_isa_pkg::op_store, rv32i_isa_pkg::sb, 5'd0, 32'h301, 32'h0000_0084);
        issue(rv32i_isa_pkg::op_load, rv32i_isa_pkg::lbu, 5'd8, 32'h301, 32'd0);
        issue(rv32i_isa_pkg::op_store, rv32i_isa_pkg::sh, 5'd0, 32'h302, 32'h0000_f00d);
        issue(rv32i_isa_pkg::op_load, rv32i_isa_pkg::lh, 5'd9, 32'h302, 32'd0);
        rand_mode = 1'b1;
        repeat (n_random) random_instr();
        go_idle();
        while (pending.size() != 0 || mem_v || wb_v) begin
            @(posedge clk);
            #5;
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/mem_wb_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_wb_path (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     stall,
    input  wire logic                                     flush,
    input  wire logic                                     in_valid,
    input  wire logic [6:0]                               in_opcode,
    input  wire logic [2:0]                               in_funct3,
    input  wire logic [rv32i_pipe_pkg::reg_addr_width-1:0] in_rd,
    input  wire logic [rv32i_pipe_pkg::xlen-1:0]          in_alu_out,
    input  wire logic [rv32i_pipe_pkg::xlen-1:0]          in_store_data,
    input  wire logic [rv32i_pipe_pkg::xlen-1:0]          dmem_rdata,
    output logic [rv32i_pipe_pkg::xlen-1:0]               dmem_address,
    output logic [rv32i_pipe_pkg::xlen-1:0]               dmem_wdata,
    output logic                                          dmem_read,
    output logic                                          dmem_write,
    output logic [rv32i_pipe_pkg::xlen/8-1:0]             dmem_byte_enable,
    output logic                                          wb_valid,
    output logic                                          wb_we,
    output logic [rv32i_pipe_pkg::reg_addr_width-1:0]     wb_rd,
    output logic [rv32i_pipe_pkg::xlen-1:0]               wb_data
);

    localparam int data_width = rv32i_pipe_pkg::xlen;

    // ex/mem side
    rv32i_pipe_pkg::ex_mem_word_t ex_mem_d;
    rv32i_pipe_pkg::ex_mem_word_t ex_mem_q;
    logic                         mem_valid;
    logic [6:0]                   mem_opcode;
    logic [2:0]                   mem_funct3;
    logic [4:0]                   mem_rd;
    logic [data_width-1:0]        mem_alu_out;
    logic [data_width-1:0]        mem_store_data;

    // mem/wb side
    rv32i_pipe_pkg::mem_wb_word_t mem_wb_d;
    rv32i_pipe_pkg::mem_wb_word_t mem_wb_q;
    logic                         wb_in_valid;
    logic [6:0]                   wb_opcode;
    logic [2:0]                   wb_funct3;
    logic [4:0]                   wb_in_rd;
    logic [data_width-1:0]        wb_alu_out;
    logic [data_width-1:0]        wb_rdata;

    assign ex_mem_d = {in_opcode, in_funct3, in_rd, in_alu_out, in_store_data};

    pipe_reg #(
        .payload_t (rv32i_pipe_pkg::ex_mem_word_t)
    ) u_ex_mem (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_payload  (ex_mem_d),
        .out_valid   (mem_valid),
        .out_payload (ex_mem_q)
    );

    assign {mem_opcode, mem_funct3, mem_rd, mem_alu_out, mem_store_data} = ex_mem_q;

    mem_stage #(
        .data_width (data_width)
    ) u_mem_stage (
        .valid            (mem_valid),
        .opcode           (mem_opcode),
        .funct3           (mem_funct3),
        .alu_out          (mem_alu_out),
        .store_data       (mem_store_data),
        .dmem_address     (dmem_address),
        .dmem_wdata       (dmem_wdata),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable)
    );

    // read data from the memory takes the store data slot
    assign mem_wb_d = {mem_opcode, mem_funct3, mem_rd, mem_alu_out, dmem_rdata};

    // flush only ever bubbles ex/mem
    pipe_reg #(
        .payload_t (rv32i_pipe_pkg::mem_wb_word_t)
    ) u_mem_wb (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (1'b0),
        .in_valid    (mem_valid),
        .in_payload  (mem_wb_d),
        .out_valid   (wb_in_valid),
        .out_payload (mem_wb_q)
    );

    assign {wb_opcode, wb_funct3, wb_in_rd, wb_alu_out, wb_rdata} = mem_wb_q;

    load_align #(
        .data_width (data_width)
    ) u_load_align (
        .valid     (wb_in_valid),
        .opcode    (wb_opcode),
        .funct3    (wb_funct3),
        .rd        (wb_in_rd),
        .alu_out   (wb_alu_out),
        .mem_rdata (wb_rdata),
        .wb_valid  (wb_valid),
        .wb_we     (wb_we),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_align #(
    parameter int data_width = 32
) (
    input  wire logic                  valid,
    input  wire logic [6:0]            opcode,
    input  wire logic [2:0]            funct3,
    input  wire logic [4:0]            rd,
    input  wire logic [data_width-1:0] alu_out,
    input  wire logic [data_width-1:0] mem_rdata,
    output logic                       wb_valid,
    output logic                       wb_we,
    output logic [4:0]                 wb_rd,
    output logic [data_width-1:0]      wb_data
);

    localparam int nbytes    = data_width / 8;
    localparam int off_width = $clog2(nbytes);

    logic [off_width-1:0]  offset;
    // addressed byte moved down to lane 0
    logic [data_width-1:0] shifted;
    logic                  is_load;
    logic                  misaligned;
    logic [data_width-1:0] load_data;
    logic                  writes_rd;

    assign offset  = alu_out[off_width-1:0];
    assign shifted = mem_rdata >> {offset, 3'b000};
    assign is_load = (opcode == rv32i_isa_pkg::op_load);

    always_comb begin
        case (funct3)
            rv32i_isa_pkg::lh, rv32i_isa_pkg::lhu: misaligned = offset[0];
            rv32i_isa_pkg::lw:                     misaligned = |offset[1:0];
            default:                               misaligned = 1'b0;
        endcase
    end

    always_comb begin
        if (misaligned) begin
            // misaligned load hands back the raw word without a trap
            load_data = mem_rdata;
        end else begin
            case (funct3)
                rv32i_isa_pkg::lb:  load_data = {{(data_width-8){shifted[7]}}, shifted[7:0]};
                rv32i_isa_pkg::lbu: load_data = {{(data_width-8){1'b0}}, shifted[7:0]};
                rv32i_isa_pkg::lh:  load_data = {{(data_width-16){shifted[15]}}, shifted[15:0]};
                rv32i_isa_pkg::lhu: load_data = {{(data_width-16){1'b0}}, shifted[15:0]};
                default:            load_data = shifted;
            endcase
        end
    end

    // opcodes that produce a register result
    always_comb begin
        case (opcode)
            rv32i_isa_pkg::op_load, rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg,
            rv32i_isa_pkg::op_lui, rv32i_isa_pkg::op_auipc,
            rv32i_isa_pkg::op_jal, rv32i_isa_pkg::op_jalr: writes_rd = 1'b1;
            // stores, branches and unknown opcodes leave the register file alone
            default:                                        writes_rd = 1'b0;
        endcase
    end

    assign wb_valid = valid;
    // x0 is hardwired to zero and never written
    assign wb_we    = valid & writes_rd & (rd != 5'd0);
    assign wb_rd    = rd;
    assign wb_data  = is_load ? load_data : alu_out;

endmodule

`default_nettype wire

// ==== logic/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
    parameter int data_width = 32
) (
    input  wire logic                    valid,
    input  wire logic [6:0]              opcode,
    input  wire logic [2:0]              funct3,
    input  wire logic [data_width-1:0]   alu_out,
    input  wire logic [data_width-1:0]   store_data,
    output logic [data_width-1:0]        dmem_address,
    output logic [data_width-1:0]        dmem_wdata,
    output logic                         dmem_read,
    output logic                         dmem_write,
    output logic [data_width/8-1:0]      dmem_byte_enable
);

    localparam int nbytes    = data_width / 8;
    localparam int off_width = $clog2(nbytes);

    // byte offset inside the bus word
    logic [off_width-1:0] offset;
    logic                 is_load;
    logic                 is_store;
    // access size in bytes or zero for an unknown store funct3
    logic [off_width:0]   size;
    logic                 aligned;
    logic [nbytes-1:0]    lane_mask;

    assign offset   = alu_out[off_width-1:0];
    assign is_load  = (opcode == rv32i_isa_pkg::op_load);
    assign is_store = (opcode == rv32i_isa_pkg::op_store);

    always_comb begin
        case (funct3)
            rv32i_isa_pkg::sb: size = (off_width + 1)'(1);
            rv32i_isa_pkg::sh: size = (off_width + 1)'(2);
            rv32i_isa_pkg::sw: size = (off_width + 1)'(4);
            default:           size = '0;
        endcase
    end

    // natural alignment needs the offset to be a multiple of the size
    assign aligned = (size != '0) &&
                     ((offset & (size[off_width-1:0] - off_width'(1))) == '0);

    // word aligned request with the low offset bits dropped
    assign dmem_address = {alu_out[data_width-1:off_width], {off_width{1'b0}}};

    // move the low bytes of store data up to the addressed lane
    assign dmem_wdata = store_data << {offset, 3'b000};

    // one enable per byte lane covered by the access
    always_comb begin
        lane_mask = '0;
        for (int i = 0; i < nbytes; i++) begin
            if ((i >= int'(offset)) && (i < int'(offset) + int'(size))) begin
                lane_mask[i] = 1'b1;
            end
        end
    end

    // misaligned sh/sw and non-stores write nothing
    assign dmem_write       = valid & is_store & aligned;
    assign dmem_byte_enable = dmem_write ? lane_mask : '0;

    // loads always read the full word and alignment happens at write-back
    assign dmem_read = valid & is_load;

endmodule

`default_nettype wire

// ==== logic/pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic stall,
    input  wire logic flush,
    input  wire logic in_valid,
    input  wire payload_t in_payload,
    output logic      out_valid,
    output payload_t  out_payload
);

    // stall wins over flush, a frozen stage keeps its instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_payload <= '0;
        end else if (!stall) begin
            // flush turns the incoming slot into a bubble
            out_valid   <= in_valid & ~flush;
            // payload of a bubble is don't care downstream
            out_payload <= in_payload;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv32i_pipe_pkg.sv ====
`default_nettype none

package rv32i_pipe_pkg;

    // datapath and address width
    localparam int xlen = 32;
    // register file index
    localparam int reg_addr_width = 5;

    // instruction field widths carried down the pipe
    localparam int opcode_width = 7;
    localparam int funct3_width = 3;

    // opcode, funct3, rd, alu result, one more data word
    localparam int stage_word_width =
        opcode_width + funct3_width + reg_addr_width + 2 * xlen;

    // ex/mem: {opcode, funct3, rd, alu_out, store_data}
    typedef logic [stage_word_width-1:0] ex_mem_word_t;

    // mem/wb: {opcode, funct3, rd, alu_out, mem_rdata}
    typedef logic [stage_word_width-1:0] mem_wb_word_t;

endpackage

`default_nettype wire

// ==== logic/rv32i_isa_pkg.sv ====
`default_nettype none

package rv32i_isa_pkg;

    // major opcodes, instr[6:0]
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal   = 7'b1101111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_br    = 7'b1100011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // load funct3
    localparam logic [2:0] lb  = 3'b000;
    localparam logic [2:0] lh  = 3'b001;
    localparam logic [2:0] lw  = 3'b010;
    localparam logic [2:0] lbu = 3'b100;
    localparam logic [2:0] lhu = 3'b101;

    // store funct3, same encodings as the signed loads
    localparam logic [2:0] sb = 3'b000;
    localparam logic [2:0] sh = 3'b001;
    localparam logic [2:0] sw = 3'b010;

endpackage

`default_nettype wire
